// File: ib_cfg.svh
`ifndef IB_CFG_SVH
`define IB_CFG_SVH

// fetch and decode width, also the number of lane FIFOs
// must stay a power of two so the lane pointers wrap naturally
`define IB_LANES 4

// entries per lane FIFO, power of two
`define IB_DEPTH 8

// instruction word width
`define IB_INSTR_W 32

`endif

// File: cpu_pkg.sv
`include "ib_cfg.svh"

package cpu_pkg;

	// one instruction word
	typedef logic [`IB_INSTR_W-1:0] instr_t;

	// count of lanes, 0 up to IB_LANES inclusive
	typedef logic [$clog2(`IB_LANES+1)-1:0] lane_cnt_t;

	typedef logic [`IB_LANES-1:0] lane_mask_t; // one bit per lane

	// rotating lane pointer
	typedef logic [$clog2(`IB_LANES)-1:0] lane_idx_t;

endpackage

// File: lane_fifo.sv
`timescale 1ns/100ps
`include "ib_cfg.svh"

module lane_fifo #(
	parameter int unsigned DEPTH = `IB_DEPTH
)(
	input  logic            clk,
	input  logic            rst_n,
	input  logic            flush_i,
	input  logic            push_i,
	input  logic            pop_i,
	input  cpu_pkg::instr_t data_i,
	output cpu_pkg::instr_t data_o,
	output logic            full_o,
	output logic            empty_o
);

	localparam int unsigned AW = $clog2(DEPTH);

	cpu_pkg::instr_t mem [DEPTH];
	logic [AW-1:0] rd_ptr;
	logic [AW-1:0] wr_ptr;
	logic [AW:0]   count; // occupancy, 0..DEPTH

	assign data_o  = mem[rd_ptr]; // head, read without a register
	assign full_o  = (count == (AW+1)'(DEPTH));
	assign empty_o = (count == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else if (flush_i) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_i) begin
				wr_ptr <= wr_ptr + 1'b1; // wraps, DEPTH is a power of two
			end
			if (pop_i) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push_i, pop_i})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (push_i && !flush_i) begin
			mem[wr_ptr] <= data_i;
		end
	end

	// the compactor holds pushes off while any lane is full
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n || flush_i)
		push_i |-> !full_o);

	// pops come from the issue window, which only counts non-empty heads
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n || flush_i)
		pop_i |-> !empty_o);

endmodule

// File: multi_queue.sv
`timescale 1ns/100ps
`include "ib_cfg.svh"

module multi_queue #(
	parameter int unsigned DEPTH = `IB_DEPTH
)(
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            flush_i,
	input  cpu_pkg::instr_t [`IB_LANES-1:0] push_data_i,
	input  cpu_pkg::lane_cnt_t              push_num_i,
	input  cpu_pkg::lane_cnt_t              pop_num_i,
	output logic                            full_o,
	output logic                            empty_o,
	output cpu_pkg::instr_t [`IB_LANES-1:0] pop_data_o,
	output cpu_pkg::lane_mask_t             pop_valid_o
);

	cpu_pkg::lane_idx_t rd_ptr; // lane holding the oldest entry
	cpu_pkg::lane_idx_t wr_ptr; // lane taking the next push

	cpu_pkg::lane_mask_t lane_push;
	cpu_pkg::lane_mask_t lane_pop;
	cpu_pkg::lane_mask_t lane_full;
	cpu_pkg::lane_mask_t lane_empty;
	cpu_pkg::lane_mask_t pop_req; // pop request, relative to rd_ptr

	cpu_pkg::instr_t [`IB_LANES-1:0] lane_din;
	cpu_pkg::instr_t [`IB_LANES-1:0] lane_dout;

	assign full_o  = |lane_full;  // stall as soon as one lane fills
	assign empty_o = &lane_empty;

	// map relative positions onto physical lanes
	always_comb begin
		lane_push = '0;
		lane_pop  = '0;
		lane_din  = '0;
		pop_req   = '0;
		for (int i = 0; i < `IB_LANES; i++) begin
			pop_req[i] = (i < pop_num_i);
			lane_din[cpu_pkg::lane_idx_t'(wr_ptr + i)]  = push_data_i[i];
			lane_push[cpu_pkg::lane_idx_t'(wr_ptr + i)] = (i < push_num_i);
			lane_pop[cpu_pkg::lane_idx_t'(rd_ptr + i)]  = pop_req[i];
		end
	end

	// read side, oldest entry at position 0
	for (genvar i = 0; i < `IB_LANES; i++) begin : gen_pop
		assign pop_data_o[i]  = lane_dout[cpu_pkg::lane_idx_t'(rd_ptr + i)];
		assign pop_valid_o[i] = !lane_empty[cpu_pkg::lane_idx_t'(rd_ptr + i)];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
		end else if (flush_i) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
		end else begin
			// a count of IB_LANES wraps back to the same lane
			rd_ptr <= rd_ptr + cpu_pkg::lane_idx_t'(pop_num_i);
			wr_ptr <= wr_ptr + cpu_pkg::lane_idx_t'(push_num_i);
		end
	end

	for (genvar g = 0; g < `IB_LANES; g++) begin : gen_lane
		lane_fifo #(
			.DEPTH   (DEPTH)
		) i_lane_fifo (
			.clk     (clk),
			.rst_n   (rst_n),
			.flush_i (flush_i),
			.push_i  (lane_push[g]),
			.pop_i   (lane_pop[g]),
			.data_i  (lane_din[g]),
			.data_o  (lane_dout[g]),
			.full_o  (lane_full[g]),
			.empty_o (lane_empty[g])
		);
	end

	// pops only cover the leading run of valid heads
	a_pop_in_valid: assert property (@(posedge clk) disable iff (!rst_n || flush_i)
		(pop_req & ~pop_valid_o) == '0);

	// fetch side must back off while stalled
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n || flush_i)
		full_o |-> (push_num_i == '0));

endmodule

// File: fetch_compactor.sv
`timescale 1ns/100ps
`include "ib_cfg.svh"

module fetch_compactor (
	input  logic                            fetch_valid_i,
	input  cpu_pkg::lane_mask_t             fetch_mask_i,
	input  cpu_pkg::instr_t [`IB_LANES-1:0] fetch_instr_i,
	input  logic                            queue_full_i,
	output cpu_pkg::instr_t [`IB_LANES-1:0] push_data_o,
	output cpu_pkg::lane_cnt_t              push_num_o,
	output logic                            fetch_stall_o
);

	cpu_pkg::lane_cnt_t slot_cnt; // masked slots seen so far
	logic               accept;

	// each valid slot moves down to the lane given by the valid slots below it
	always_comb begin
		slot_cnt    = '0;
		push_data_o = '0;
		for (int s = 0; s < `IB_LANES; s++) begin
			if (fetch_mask_i[s]) begin
				push_data_o[cpu_pkg::lane_idx_t'(slot_cnt)] = fetch_instr_i[s];
				slot_cnt = slot_cnt + 1'b1;
			end
		end
	end

	// whole group or nothing
	assign accept     = fetch_valid_i && !queue_full_i;
	assign push_num_o = accept ? slot_cnt : '0;

	// fetch holds the group while this is high
	assign fetch_stall_o = queue_full_i;

endmodule

// File: issue_window.sv
`timescale 1ns/100ps
`include "ib_cfg.svh"

module issue_window (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            flush_i,
	input  cpu_pkg::instr_t [`IB_LANES-1:0] pop_data_i,
	input  cpu_pkg::lane_mask_t             pop_valid_i,
	input  cpu_pkg::lane_cnt_t              dec_slots_i,
	output cpu_pkg::lane_cnt_t              pop_num_o,
	output cpu_pkg::instr_t [`IB_LANES-1:0] dec_instr_o,
	output cpu_pkg::lane_mask_t             dec_valid_o
);

	cpu_pkg::lane_cnt_t  lead_cnt;   // valid positions from 0 up to the first gap
	cpu_pkg::lane_mask_t issue_mask; // thermometer of pop_num_o
	logic                run;

	always_comb begin
		lead_cnt = '0;
		run      = 1'b1;
		for (int i = 0; i < `IB_LANES; i++) begin
			run = run & pop_valid_i[i];
			if (run) begin
				lead_cnt = lead_cnt + 1'b1;
			end
		end
	end

	// take no more than the decoder has room for
	assign pop_num_o = (dec_slots_i < lead_cnt) ? dec_slots_i : lead_cnt;

	always_comb begin
		for (int i = 0; i < `IB_LANES; i++) begin
			issue_mask[i] = (i < pop_num_o);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dec_valid_o <= '0;
		end else if (flush_i) begin
			dec_valid_o <= '0; // popped words are dropped with the queue
		end else begin
			dec_valid_o <= issue_mask;
		end
	end

	always_ff @(posedge clk) begin
		dec_instr_o <= pop_data_i; // lanes past the valid run are don't care
	end

	// valid lanes form one run starting at lane 0
	a_valid_contig: assert property (@(posedge clk) disable iff (!rst_n)
		(dec_valid_o & cpu_pkg::lane_mask_t'(dec_valid_o + 1'b1)) == '0);

endmodule

// File: instr_buffer_top.sv
`timescale 1ns/100ps
`include "ib_cfg.svh"

module instr_buffer_top (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            flush_i,
	input  logic                            fetch_valid_i,
	input  cpu_pkg::lane_mask_t             fetch_mask_i,
	input  cpu_pkg::instr_t [`IB_LANES-1:0] fetch_instr_i,
	input  cpu_pkg::lane_cnt_t              dec_slots_i,
	output logic                            fetch_stall_o,
	output cpu_pkg::instr_t [`IB_LANES-1:0] dec_instr_o,
	output cpu_pkg::lane_mask_t             dec_valid_o,
	output logic                            buf_empty_o
);

	cpu_pkg::instr_t [`IB_LANES-1:0] q_push_data;
	cpu_pkg::lane_cnt_t              q_push_num;
	cpu_pkg::instr_t [`IB_LANES-1:0] q_pop_data;
	cpu_pkg::lane_mask_t             q_pop_valid;
	cpu_pkg::lane_cnt_t              q_pop_num;
	logic                            q_full;

	fetch_compactor i_fetch_compactor (
		.fetch_valid_i (fetch_valid_i),
		.fetch_mask_i  (fetch_mask_i),
		.fetch_instr_i (fetch_instr_i),
		.queue_full_i  (q_full),
		.push_data_o   (q_push_data),
		.push_num_o    (q_push_num),
		.fetch_stall_o (fetch_stall_o)
	);

	multi_queue #(
		.DEPTH       (`IB_DEPTH)
	) i_multi_queue (
		.clk         (clk),
		.rst_n       (rst_n),
		.flush_i     (flush_i),
		.push_data_i (q_push_data),
		.push_num_i  (q_push_num),
		.pop_num_i   (q_pop_num),
		.full_o      (q_full),
		.empty_o     (buf_empty_o), // queue empty is the buffer status
		.pop_data_o  (q_pop_data),
		.pop_valid_o (q_pop_valid)
	);

	issue_window i_issue_window (
		.clk         (clk),
		.rst_n       (rst_n),
		.flush_i     (flush_i),
		.pop_data_i  (q_pop_data),
		.pop_valid_i (q_pop_valid),
		.dec_slots_i (dec_slots_i),
		.pop_num_o   (q_pop_num),
		.dec_instr_o (dec_instr_o),
		.dec_valid_o (dec_valid_o)
	);

endmodule

// File: tb_instr_buffer.sv
`timescale 1ns/100ps
`include "ib_cfg.svh"

module tb_instr_buffer;

	localparam int LANES = `IB_LANES;
	localparam int STALL_FREE_MAX = `IB_LANES * (`IB_DEPTH - 1); // stall never seen at or below
	localparam int CAPACITY = `IB_LANES * `IB_DEPTH;
	localparam int DC = 2; // don't care in the expectation columns

	typedef struct packed {
		logic       fv;
		logic [3:0] mask;
		logic [2:0] slots;
		logic       flush;
		logic [7:0] reps;
		logic [1:0] exp_stall; // 0, 1 or DC at the last cycle of the row
		logic [1:0] exp_empty;
	} row_t;

	logic                            clk;
	logic                            rst_n;
	logic                            flush_i;
	logic                            fetch_valid_i;
	cpu_pkg::lane_mask_t             fetch_mask_i;
	cpu_pkg::instr_t [`IB_LANES-1:0] fetch_instr_i;
	cpu_pkg::lane_cnt_t              dec_slots_i;
	logic                            fetch_stall_o;
	cpu_pkg::instr_t [`IB_LANES-1:0] dec_instr_o;
	cpu_pkg::lane_mask_t             dec_valid_o;
	logic                            buf_empty_o;

	row_t            rows[$];
	cpu_pkg::instr_t model_q[$]; // words accepted and not yet seen at decode
	int unsigned     seq;
	int unsigned     wd_cycles;
	int              errors;
	int              checks;
	logic            taken;      // group accepted at the coming edge
	logic            row_end;
	int              row_exp_stall;
	int              row_exp_empty;
	int              prev_qcnt;
	int              prev_slots;
	logic            prev_flush;

	instr_buffer_top i_instr_buffer_top (
		.clk           (clk),
		.rst_n         (rst_n),
		.flush_i       (flush_i),
		.fetch_valid_i (fetch_valid_i),
		.fetch_mask_i  (fetch_mask_i),
		.fetch_instr_i (fetch_instr_i),
		.dec_slots_i   (dec_slots_i),
		.fetch_stall_o (fetch_stall_o),
		.dec_instr_o   (dec_instr_o),
		.dec_valid_o   (dec_valid_o),
		.buf_empty_o   (buf_empty_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic add_row(input logic fv, input logic [3:0] mask, input int slots,
			input logic flush, input int reps, input int exp_stall, input int exp_empty);
		row_t r;
		r.fv        = fv;
		r.mask      = mask;
		r.slots     = 3'(slots);
		r.flush     = flush;
		r.reps      = 8'(reps);
		r.exp_stall = 2'(exp_stall);
		r.exp_empty = 2'(exp_empty);
		rows.push_back(r);
	endtask

	task automatic build_table();
		// sparse masks go through decode in order
		add_row(1, 4'b0101, 4, 0, 6, 0, DC);
		add_row(1, 4'b1000, 4, 0, 5, 0, DC);
		add_row(1, 4'b0110, 2, 0, 6, DC, DC);
		add_row(1, 4'b1111, 1, 0, 4, DC, DC);
		add_row(1, 4'b0000, 3, 0, 2, DC, DC);
		add_row(1, 4'b1001, 3, 0, 5, DC, DC);
		add_row(0, 4'b0000, 4, 0, 12, 0, 1);  // drain
		// decoder blocked so the buffer fills up to 32 words
		add_row(1, 4'b1111, 0, 0, 12, 1, 0);
		add_row(1, 4'b1111, 1, 0, 10, DC, 0);
		add_row(1, 4'b1010, 0, 0, 6, DC, 0);
		add_row(0, 4'b0000, 4, 0, 14, 0, 1);
		add_row(1, 4'b1011, 3, 0, 8, DC, DC);
		add_row(1, 4'b1111, 4, 0, 6, DC, DC);
		// flush and then new words come out first
		add_row(1, 4'b1111, 4, 1, 1, DC, DC);
		add_row(1, 4'b0011, 4, 0, 4, 0, DC);
		add_row(0, 4'b0000, 4, 0, 6, 0, 1);
		add_row(1, 4'b1111, 2, 0, 10, DC, 0);
		add_row(1, 4'b0110, 3, 1, 2, DC, DC); // flush held for two edges
		add_row(1, 4'b1100, 2, 0, 5, DC, DC);
		add_row(0, 4'b0000, 4, 0, 10, 0, 1);
	endtask

	// fresh words for all four slots with a running number in the low half
	task automatic new_group();
		logic [31:0] rnd;
		for (int s = 0; s < LANES; s++) begin
			rnd = $urandom();
			seq = seq + 1;
			fetch_instr_i[s] = cpu_pkg::instr_t'({rnd[31:16], seq[15:0]});
		end
	endtask

	// at mid-cycle compare what decode sees and predict the coming edge
	always @(negedge clk) begin : monitor
		int                  n_exp;
		int                  qcnt;
		cpu_pkg::lane_mask_t exp_mask;
		cpu_pkg::instr_t     exp_word;
		if (rst_n) begin
			n_exp = (prev_qcnt < prev_slots) ? prev_qcnt : prev_slots;
			if (prev_flush) begin
				n_exp = 0; // flush discards the pop of that edge
			end
			exp_mask = cpu_pkg::lane_mask_t'((1 << n_exp) - 1);
			checks++;
			assert (dec_valid_o == exp_mask) else begin
				$display("CHECK FAILED dec_valid_o: got %h expected %h", dec_valid_o, exp_mask);
				errors++;
			end
			for (int i = 0; i < LANES; i++) begin
				if (dec_valid_o[i]) begin
					assert (model_q.size() != 0) else begin
						$display("decode lane %0d shows a word that was never accepted", i);
						errors++;
					end
					if (model_q.size() != 0) begin
						exp_word = model_q.pop_front();
						checks++;
						assert (dec_instr_o[i] == exp_word) else begin
							$display("CHECK FAILED dec_instr_o[%0d]: got %h expected %h",
								i, dec_instr_o[i], exp_word);
							errors++;
						end
					end
				end
			end
			qcnt = model_q.size(); // now equal to the queue occupancy
			checks++;
			assert (buf_empty_o == (qcnt == 0)) else begin
				$display("CHECK FAILED buf_empty_o: got %h expected %h", buf_empty_o, qcnt == 0);
				errors++;
			end
			assert (!(fetch_stall_o && qcnt <= STALL_FREE_MAX)) else begin
				$display("CHECK FAILED fetch_stall_o: got %h expected %h", fetch_stall_o, 1'b0);
				errors++;
			end
			assert (fetch_stall_o || qcnt < CAPACITY) else begin
				$display("CHECK FAILED fetch_stall_o: got %h expected %h", fetch_stall_o, 1'b1);
				errors++;
			end
			if (row_end && row_exp_stall != DC) begin
				assert (fetch_stall_o == row_exp_stall[0]) else begin
					$display("CHECK FAILED fetch_stall_o: got %h expected %h",
						fetch_stall_o, row_exp_stall[0]);
					errors++;
				end
			end
			if (row_end && row_exp_empty != DC) begin
				assert (buf_empty_o == row_exp_empty[0]) else begin
					$display("CHECK FAILED buf_empty_o: got %h expected %h",
						buf_empty_o, row_exp_empty[0]);
					errors++;
				end
			end
			taken = 1'b0;
			if (flush_i) begin
				model_q.delete();
			end else if (fetch_valid_i && !fetch_stall_o) begin
				for (int s = 0; s < LANES; s++) begin
					if (fetch_mask_i[s]) begin
						model_q.push_back(fetch_instr_i[s]); // slot order
					end
				end
				taken = 1'b1;
			end
			prev_qcnt  = qcnt;
			prev_slots = int'(dec_slots_i);
			prev_flush = flush_i;
		end
	end

	initial begin : watchdog
		wait (wd_cycles != 0);
		#(wd_cycles * 10);
		$display("watchdog timeout, run did not finish within %0d cycles", wd_cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin : stimulus
		int unsigned total;
		void'($urandom(48));
		rst_n         = 1'b0;
		flush_i       = 1'b0;
		fetch_valid_i = 1'b0;
		fetch_mask_i  = '0;
		fetch_instr_i = '0;
		dec_slots_i   = '0;
		seq           = 0;
		errors        = 0;
		checks        = 0;
		taken         = 1'b0;
		row_end       = 1'b0;
		row_exp_stall = DC;
		row_exp_empty = DC;
		prev_qcnt     = 0;
		prev_slots    = 0;
		prev_flush    = 1'b0;
		build_table();
		total = 0;
		foreach (rows[r]) begin
			total += rows[r].reps;
		end
		wd_cycles = total + 3 + 40; // reset plus margin
		new_group();
		repeat (3) @(posedge clk);
		#1 rst_n = 1'b1;
		foreach (rows[r]) begin
			for (int k = 0; k < int'(rows[r].reps); k++) begin
				@(posedge clk);
				#1;
				if (taken) begin
					new_group(); // otherwise fetch keeps offering the same group
				end
				fetch_valid_i = rows[r].fv;
				fetch_mask_i  = rows[r].mask;
				dec_slots_i   = rows[r].slots;
				flush_i       = rows[r].flush;
				row_end       = (k == int'(rows[r].reps) - 1);
				row_exp_stall = int'(rows[r].exp_stall);
				row_exp_empty = int'(rows[r].exp_empty);
			end
		end
		@(posedge clk);
		#1;
		fetch_valid_i = 1'b0;
		flush_i       = 1'b0;
		row_end       = 1'b0;
		repeat (4) @(posedge clk);
		$display("checks: %0d  errors: %0d  words left in model: %0d",
			checks, errors, model_q.size());
		if (errors == 0 && model_q.size() == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: project.f
+incdir+.
cpu_pkg.sv
lane_fifo.sv
multi_queue.sv
fetch_compactor.sv
issue_window.sv
instr_buffer_top.sv
tb_instr_buffer.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_instr_buffer \
	-f project.f

./obj_dir/Vtb_instr_buffer > sim.log 2>&1
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "simulation reported failure, see sim.log"
	exit 1
fi

echo "simulation finished without failure"
exit 0
